// File: hw/raystore_defs.svh
// Ray store sizes
`ifndef RAYSTORE_DEFS_SVH
`define RAYSTORE_DEFS_SVH

// bits in a ray id
`define RS_ADDR_W 9

// rays held
`define RS_DEPTH 512

// 32-bit words per ray, origin xyz then dir xyz
`define RS_WORDS 6

// response queue entries per lane
`define RS_QDEPTH 2

`endif

// File: hw/raystore_pkg.sv
// Ray store types
`default_nettype none

`include "raystore_defs.svh"

package raystore_pkg;

	typedef logic [31:0] float_t;
	typedef logic [`RS_ADDR_W-1:0] ray_id_t;
	typedef logic [15:0] node_id_t;
	typedef logic [15:0] tri_id_t;

	typedef struct packed {
		float_t x;
		float_t y;
		float_t z;
	} vec3_t;

	// origin sits in the upper three words
	typedef struct packed {
		vec3_t origin;
		vec3_t dir;
	} ray_vec_t;

	typedef enum logic [1:0] {
		axis_x = 2'd0,
		axis_y = 2'd1,
		axis_z = 2'd2,
		leaf   = 2'd3
	} node_type_t;

	typedef struct packed {
		ray_id_t    ray_id;
		node_id_t   node_id;
		node_type_t node_type;
		float_t     t_min;
		float_t     t_max;
	} trav_req_t;

	typedef struct packed {
		ray_id_t    ray_id;
		node_id_t   node_id;
		node_type_t node_type;
		float_t     t_min;
		float_t     t_max;
		float_t     origin;
		float_t     dir;
	} trav_resp_t;

	typedef struct packed {
		ray_id_t ray_id;
		tri_id_t tri_id;
	} ic_req_t;

	typedef struct packed {
		ray_id_t  ray_id;
		tri_id_t  tri_id;
		ray_vec_t ray;
	} ic_resp_t;

	typedef enum logic [1:0] {
		trav0  = 2'd0,
		trav1  = 2'd1,
		icache = 2'd2
	} port_sel_t;

endpackage : raystore_pkg

`default_nettype wire

// File: hw/rs_arb.sv
// Ray store arbiter
`timescale 1ns/1ps
`default_nettype none

module rs_arb (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire logic [2:0]           req_valid,
	input  wire logic [2:0]           lane_ready,
	input  wire logic                 port_a_busy,
	output logic [2:0]                grant,
	output logic [2:0]                data_sel,
	output raystore_pkg::port_sel_t   sel_a,
	output raystore_pkg::port_sel_t   sel_b,
	output logic [2:0]                req_stall
);

	logic [1:0] rr_ptr;
	logic [2:0] eligible;

	assign eligible = req_valid & lane_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rr_ptr <= 2'd0;
		end else if (|req_valid) begin
			rr_ptr <= (rr_ptr == 2'd2) ? 2'd0 : rr_ptr + 2'd1;
		end
	end

	// walk clients from the pointer, first pick to port a, second to port b
	always_comb begin : pick
		int          slot;
		int unsigned taken;
		int unsigned limit;
		logic [1:0]  idx;

		grant = '0;
		data_sel = '0;
		sel_a = raystore_pkg::trav0;
		sel_b = raystore_pkg::trav0;
		taken = 0;
		limit = port_a_busy ? 1 : 2;
		for (int k = 0; k < 3; k++) begin
			slot = rr_ptr + k;
			if (slot >= 3)
				slot = slot - 3;
			idx = slot[1:0];
			if (eligible[idx] && taken < limit) begin
				grant[idx] = 1'b1;
				if (!port_a_busy && taken == 0) begin
					sel_a = raystore_pkg::port_sel_t'(idx);
				end else begin
					sel_b = raystore_pkg::port_sel_t'(idx);
					data_sel[idx] = 1'b1;
				end
				taken++;
			end
		end
	end

	assign req_stall = req_valid & ~grant;

	// two RAM read ports bound the grants
	a_max_two_grants: assert property (
		@(posedge clk) disable iff (!rst_n) $countones(grant) <= 2
	) else $error("more than two grants");

	// host access owns port a
	a_no_port_a_when_busy: assert property (
		@(posedge clk) disable iff (!rst_n) port_a_busy |-> !(|(grant & ~data_sel))
	) else $error("port a granted while host busy");

endmodule : rs_arb

`default_nettype wire

// File: hw/rs_ray_ram.sv
// Dual port ray memory
`timescale 1ns/1ps
`default_nettype none

`include "raystore_defs.svh"

module rs_ray_ram (
	input  wire logic                   clk,
	input  wire raystore_pkg::ray_id_t  addr_a,
	input  wire logic [`RS_WORDS-1:0]   wen_a,
	input  wire raystore_pkg::float_t   wdata_a,
	output raystore_pkg::ray_vec_t      q_a,
	input  wire raystore_pkg::ray_id_t  addr_b,
	output raystore_pkg::ray_vec_t      q_b
);

	localparam int WORD_W = $bits(raystore_pkg::float_t);

	raystore_pkg::ray_vec_t mem [`RS_DEPTH];

	// word 0 is origin x, the top word of the packed vector
	always_ff @(posedge clk) begin
		for (int w = 0; w < `RS_WORDS; w++) begin
			if (wen_a[w])
				mem[addr_a][(`RS_WORDS - 1 - w) * WORD_W +: WORD_W] <= wdata_a;
		end
		q_a <= mem[addr_a];
	end

	// read only port
	always_ff @(posedge clk) begin
		q_b <= mem[addr_b];
	end

	a_one_word_write: assert property (
		@(posedge clk) $onehot0(wen_a)
	) else $error("several word enables at once");

endmodule : rs_ray_ram

`default_nettype wire

// File: hw/rs_wb_port.sv
// Wishbone host port
`timescale 1ns/1ps
`default_nettype none

`include "raystore_defs.svh"

module rs_wb_port (
	input  wire logic                      clk,
	input  wire logic                      rst_n,
	input  wire logic                      wb_cyc,
	input  wire logic                      wb_stb,
	input  wire logic                      wb_we,
	input  wire logic [`RS_ADDR_W+2:0]     wb_adr,
	input  wire logic [31:0]               wb_dat_w,
	output logic [31:0]                    wb_dat_r,
	output logic                           wb_ack,
	output logic                           port_a_busy,
	output raystore_pkg::ray_id_t          ram_addr,
	output logic [`RS_WORDS-1:0]           ram_wen,
	output raystore_pkg::float_t           ram_wdata,
	input  wire raystore_pkg::ray_vec_t    ram_q
);

	logic       req;
	logic [2:0] word;
	logic [2:0] word_q;

	assign req = wb_cyc & wb_stb;
	assign word = wb_adr[2:0];
	assign port_a_busy = req;
	assign ram_addr = wb_adr[`RS_ADDR_W+2:3];
	assign ram_wdata = wb_dat_w;

	// words 6 and 7 drop writes
	always_comb begin
		ram_wen = '0;
		if (req && wb_we && !wb_ack && word < `RS_WORDS)
			ram_wen[word] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= req & ~wb_ack;
	end

	always_ff @(posedge clk) begin
		if (req && !wb_ack)
			word_q <= word;
	end

	// RAM output lands in the ack cycle
	always_comb begin
		case (word_q)
			3'd0: wb_dat_r = ram_q.origin.x;
			3'd1: wb_dat_r = ram_q.origin.y;
			3'd2: wb_dat_r = ram_q.origin.z;
			3'd3: wb_dat_r = ram_q.dir.x;
			3'd4: wb_dat_r = ram_q.dir.y;
			3'd5: wb_dat_r = ram_q.dir.z;
			default: wb_dat_r = '0;
		endcase
	end

	a_single_ack: assert property (
		@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack
	) else $error("ack held for two cycles");

endmodule : rs_wb_port

`default_nettype wire

// File: hw/rs_trav_lane.sv
// Traversal response lane
`timescale 1ns/1ps
`default_nettype none

`include "raystore_defs.svh"

module rs_trav_lane (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    grant,
	input  wire logic                    data_sel,
	input  wire raystore_pkg::trav_req_t req,
	input  wire raystore_pkg::ray_vec_t  q_a,
	input  wire raystore_pkg::ray_vec_t  q_b,
	output logic                         ready,
	output raystore_pkg::trav_resp_t     resp,
	output logic                         resp_valid,
	input  wire logic                    resp_stall
);

	localparam int PTR_W = $clog2(`RS_QDEPTH);
	localparam int CNT_W = $clog2(`RS_QDEPTH + 1);

	raystore_pkg::trav_req_t  req_q;
	raystore_pkg::ray_vec_t   vec;
	raystore_pkg::trav_resp_t entry;
	raystore_pkg::trav_resp_t queue [`RS_QDEPTH];
	logic                     sel_q;
	logic                     inflight;
	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [CNT_W-1:0]         count;
	logic                     push;
	logic                     pop;

	// request waits here while the RAM reads
	always_ff @(posedge clk) begin
		if (grant) begin
			req_q <= req;
			sel_q <= data_sel;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			inflight <= 1'b0;
		else
			inflight <= grant;
	end

	assign vec = sel_q ? q_b : q_a;

	always_comb begin
		entry.ray_id = req_q.ray_id;
		entry.node_id = req_q.node_id;
		entry.node_type = req_q.node_type;
		entry.t_min = req_q.t_min;
		entry.t_max = req_q.t_max;
		case (req_q.node_type)
			raystore_pkg::axis_x: begin
				entry.origin = vec.origin.x;
				entry.dir = vec.dir.x;
			end
			raystore_pkg::axis_y: begin
				entry.origin = vec.origin.y;
				entry.dir = vec.dir.y;
			end
			raystore_pkg::axis_z: begin
				entry.origin = vec.origin.z;
				entry.dir = vec.dir.z;
			end
			default: begin
				entry.origin = '0;
				entry.dir = '0;
			end
		endcase
	end

	assign push = inflight;
	assign pop = resp_valid & ~resp_stall;

	always_ff @(posedge clk) begin
		if (push)
			queue[wr_ptr] <= entry;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign resp_valid = (count != '0);
	assign resp = queue[rd_ptr];

	// in-flight read holds a slot too
	assign ready = (count + inflight) < `RS_QDEPTH;

	a_no_overflow: assert property (
		@(posedge clk) disable iff (!rst_n) push |-> (count < `RS_QDEPTH || pop)
	) else $error("push into full queue");

endmodule : rs_trav_lane

`default_nettype wire

// File: hw/rs_icache_lane.sv
// Intersection cache response lane
`timescale 1ns/1ps
`default_nettype none

`include "raystore_defs.svh"

module rs_icache_lane (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   grant,
	input  wire logic                   data_sel,
	input  wire raystore_pkg::ic_req_t  req,
	input  wire raystore_pkg::ray_vec_t q_a,
	input  wire raystore_pkg::ray_vec_t q_b,
	output logic                        ready,
	output raystore_pkg::ic_resp_t      resp,
	output logic                        resp_valid,
	input  wire logic                   resp_stall
);

	localparam int PTR_W = $clog2(`RS_QDEPTH);
	localparam int CNT_W = $clog2(`RS_QDEPTH + 1);

	raystore_pkg::ic_req_t  req_q;
	raystore_pkg::ic_resp_t entry;
	raystore_pkg::ic_resp_t queue [`RS_QDEPTH];
	logic                   sel_q;
	logic                   inflight;
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;
	logic [CNT_W-1:0]       count;
	logic                   pop;

	always_ff @(posedge clk) begin
		if (grant) begin
			req_q <= req;
			sel_q <= data_sel;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			inflight <= 1'b0;
		else
			inflight <= grant;
	end

	// whole ray from whichever port served it
	assign entry.ray_id = req_q.ray_id;
	assign entry.tri_id = req_q.tri_id;
	assign entry.ray = sel_q ? q_b : q_a;

	assign pop = resp_valid & ~resp_stall;

	always_ff @(posedge clk) begin
		if (inflight)
			queue[wr_ptr] <= entry;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (inflight)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({inflight, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign resp_valid = (count != '0);
	assign resp = queue[rd_ptr];
	assign ready = (count + inflight) < `RS_QDEPTH;

endmodule : rs_icache_lane

`default_nettype wire

// File: hw/raystore_top.sv
// Ray store top level
`timescale 1ns/1ps
`default_nettype none

`include "raystore_defs.svh"

module raystore_top (
	input  wire logic                    clk,
	input  wire logic                    rst_n,

	input  wire raystore_pkg::trav_req_t trav0_req,
	input  wire logic                    trav0_req_valid,
	output logic                         trav0_req_stall,
	input  wire raystore_pkg::trav_req_t trav1_req,
	input  wire logic                    trav1_req_valid,
	output logic                         trav1_req_stall,
	input  wire raystore_pkg::ic_req_t   ic_req,
	input  wire logic                    ic_req_valid,
	output logic                         ic_req_stall,

	output raystore_pkg::trav_resp_t     trav0_resp,
	output logic                         trav0_resp_valid,
	input  wire logic                    trav0_resp_stall,
	output raystore_pkg::trav_resp_t     trav1_resp,
	output logic                         trav1_resp_valid,
	input  wire logic                    trav1_resp_stall,
	output raystore_pkg::ic_resp_t       ic_resp,
	output logic                         ic_resp_valid,
	input  wire logic                    ic_resp_stall,

	input  wire logic                    wb_cyc,
	input  wire logic                    wb_stb,
	input  wire logic                    wb_we,
	input  wire logic [`RS_ADDR_W+2:0]   wb_adr,
	input  wire logic [31:0]             wb_dat_w,
	output logic [31:0]                  wb_dat_r,
	output logic                         wb_ack
);

	logic [2:0]              req_valid;
	logic [2:0]              lane_ready;
	logic [2:0]              grant;
	logic [2:0]              data_sel;
	logic [2:0]              req_stall;
	logic                    port_a_busy;
	raystore_pkg::port_sel_t sel_a;
	raystore_pkg::port_sel_t sel_b;
	raystore_pkg::ray_id_t   client_id [3];
	raystore_pkg::ray_id_t   wb_addr;
	raystore_pkg::ray_id_t   addr_a;
	raystore_pkg::ray_id_t   addr_b;
	logic [`RS_WORDS-1:0]    wen_a;
	raystore_pkg::float_t    wdata_a;
	raystore_pkg::ray_vec_t  q_a;
	raystore_pkg::ray_vec_t  q_b;

	// bit order follows port_sel_t
	assign req_valid = {ic_req_valid, trav1_req_valid, trav0_req_valid};
	assign {ic_req_stall, trav1_req_stall, trav0_req_stall} = req_stall;

	assign client_id[0] = trav0_req.ray_id;
	assign client_id[1] = trav1_req.ray_id;
	assign client_id[2] = ic_req.ray_id;

	// host takes port a whenever it is busy
	assign addr_a = port_a_busy ? wb_addr : client_id[sel_a];
	assign addr_b = client_id[sel_b];

	rs_arb i_arb (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid   (req_valid),
		.lane_ready  (lane_ready),
		.port_a_busy (port_a_busy),
		.grant       (grant),
		.data_sel    (data_sel),
		.sel_a       (sel_a),
		.sel_b       (sel_b),
		.req_stall   (req_stall)
	);

	rs_ray_ram i_ram (
		.clk     (clk),
		.addr_a  (addr_a),
		.wen_a   (wen_a),
		.wdata_a (wdata_a),
		.q_a     (q_a),
		.addr_b  (addr_b),
		.q_b     (q_b)
	);

	rs_wb_port i_wb (
		.clk         (clk),
		.rst_n       (rst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.port_a_busy (port_a_busy),
		.ram_addr    (wb_addr),
		.ram_wen     (wen_a),
		.ram_wdata   (wdata_a),
		.ram_q       (q_a)
	);

	rs_trav_lane i_trav0_lane (
		.clk        (clk),
		.rst_n      (rst_n),
		.grant      (grant[0]),
		.data_sel   (data_sel[0]),
		.req        (trav0_req),
		.q_a        (q_a),
		.q_b        (q_b),
		.ready      (lane_ready[0]),
		.resp       (trav0_resp),
		.resp_valid (trav0_resp_valid),
		.resp_stall (trav0_resp_stall)
	);

	rs_trav_lane i_trav1_lane (
		.clk        (clk),
		.rst_n      (rst_n),
		.grant      (grant[1]),
		.data_sel   (data_sel[1]),
		.req        (trav1_req),
		.q_a        (q_a),
		.q_b        (q_b),
		.ready      (lane_ready[1]),
		.resp       (trav1_resp),
		.resp_valid (trav1_resp_valid),
		.resp_stall (trav1_resp_stall)
	);

	rs_icache_lane i_ic_lane (
		.clk        (clk),
		.rst_n      (rst_n),
		.grant      (grant[2]),
		.data_sel   (data_sel[2]),
		.req        (ic_req),
		.q_a        (q_a),
		.q_b        (q_b),
		.ready      (lane_ready[2]),
		.resp       (ic_resp),
		.resp_valid (ic_resp_valid),
		.resp_stall (ic_resp_stall)
	);

endmodule : raystore_top

`default_nettype wire

// File: bench/raystore_tb.sv
// Ray store directed testbench
`timescale 1ns/1ps
`default_nettype none

`include "raystore_defs.svh"

module raystore_tb;

	// directed sequence runs well inside this many cycles
	localparam int MAX_CYCLES = 4000;

	logic                     clk;
	logic                     rst_n;
	raystore_pkg::trav_req_t  trav0_req;
	logic                     trav0_req_valid;
	logic                     trav0_req_stall;
	raystore_pkg::trav_req_t  trav1_req;
	logic                     trav1_req_valid;
	logic                     trav1_req_stall;
	raystore_pkg::ic_req_t    ic_req;
	logic                     ic_req_valid;
	logic                     ic_req_stall;
	raystore_pkg::trav_resp_t trav0_resp;
	logic                     trav0_resp_valid;
	logic                     trav0_resp_stall;
	raystore_pkg::trav_resp_t trav1_resp;
	logic                     trav1_resp_valid;
	logic                     trav1_resp_stall;
	raystore_pkg::ic_resp_t   ic_resp;
	logic                     ic_resp_valid;
	logic                     ic_resp_stall;
	logic                     wb_cyc;
	logic                     wb_stb;
	logic                     wb_we;
	logic [`RS_ADDR_W+2:0]    wb_adr;
	logic [31:0]              wb_dat_w;
	logic [31:0]              wb_dat_r;
	logic                     wb_ack;

	// expected ray words with origin xyz in 0 to 2 and dir xyz in 3 to 5
	raystore_pkg::float_t     model [`RS_DEPTH][`RS_WORDS];
	raystore_pkg::ray_id_t    ray_set [16];
	raystore_pkg::ray_id_t    new_set [8];
	raystore_pkg::trav_resp_t exp_trav0 [$];
	raystore_pkg::trav_resp_t exp_trav1 [$];
	raystore_pkg::ic_resp_t   exp_ic [$];
	int                       accepted [3];
	int                       seed = 32'h11b0;
	int                       cycles = 0;
	int                       n_accept;

	raystore_top i_dut (
		.clk              (clk),
		.rst_n            (rst_n),
		.trav0_req        (trav0_req),
		.trav0_req_valid  (trav0_req_valid),
		.trav0_req_stall  (trav0_req_stall),
		.trav1_req        (trav1_req),
		.trav1_req_valid  (trav1_req_valid),
		.trav1_req_stall  (trav1_req_stall),
		.ic_req           (ic_req),
		.ic_req_valid     (ic_req_valid),
		.ic_req_stall     (ic_req_stall),
		.trav0_resp       (trav0_resp),
		.trav0_resp_valid (trav0_resp_valid),
		.trav0_resp_stall (trav0_resp_stall),
		.trav1_resp       (trav1_resp),
		.trav1_resp_valid (trav1_resp_valid),
		.trav1_resp_stall (trav1_resp_stall),
		.ic_resp          (ic_resp),
		.ic_resp_valid    (ic_resp_valid),
		.ic_resp_stall    (ic_resp_stall),
		.wb_cyc           (wb_cyc),
		.wb_stb           (wb_stb),
		.wb_we            (wb_we),
		.wb_adr           (wb_adr),
		.wb_dat_w         (wb_dat_w),
		.wb_dat_r         (wb_dat_r),
		.wb_ack           (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at %0t", $time);
	endtask

	task automatic check_eq(input string name, input logic [255:0] got,
			input logic [255:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run("value check failed");
		end
	endtask

	function automatic raystore_pkg::ray_vec_t ray_of(input raystore_pkg::ray_id_t id);
		raystore_pkg::ray_vec_t r;
		r.origin.x = model[id][0];
		r.origin.y = model[id][1];
		r.origin.z = model[id][2];
		r.dir.x = model[id][3];
		r.dir.y = model[id][4];
		r.dir.z = model[id][5];
		return r;
	endfunction

	function automatic raystore_pkg::trav_resp_t expect_trav(
			input raystore_pkg::trav_req_t req);
		raystore_pkg::trav_resp_t e;
		int axis;
		axis = int'(req.node_type);
		e.ray_id = req.ray_id;
		e.node_id = req.node_id;
		e.node_type = req.node_type;
		e.t_min = req.t_min;
		e.t_max = req.t_max;
		// leaf carries no axis
		if (req.node_type == raystore_pkg::leaf) begin
			e.origin = '0;
			e.dir = '0;
		end else begin
			e.origin = model[req.ray_id][axis];
			e.dir = model[req.ray_id][axis + 3];
		end
		return e;
	endfunction

	function automatic raystore_pkg::trav_req_t random_trav_req();
		raystore_pkg::trav_req_t r;
		logic [1:0] nt;
		r.ray_id = ray_set[$random(seed) & 15];
		r.node_id = $random(seed);
		nt = $random(seed);
		r.node_type = raystore_pkg::node_type_t'(nt);
		r.t_min = $random(seed);
		r.t_max = $random(seed);
		return r;
	endfunction

	function automatic raystore_pkg::ic_req_t random_ic_req();
		raystore_pkg::ic_req_t r;
		r.ray_id = ray_set[$random(seed) & 15];
		r.tri_id = $random(seed);
		return r;
	endfunction

	// all tasks below start and end 2 ns after a rising edge
	task automatic wb_write(input raystore_pkg::ray_id_t id, input logic [2:0] word,
			input raystore_pkg::float_t data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = {id, word};
		wb_dat_w = data;
		@(negedge clk);
		check_eq("wb_ack", wb_ack, 1'b0);
		@(negedge clk);
		check_eq("wb_ack", wb_ack, 1'b1);
		@(posedge clk);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input raystore_pkg::ray_id_t id, input logic [2:0] word,
			output raystore_pkg::float_t data);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = {id, word};
		@(negedge clk);
		check_eq("wb_ack", wb_ack, 1'b0);
		@(negedge clk);
		check_eq("wb_ack", wb_ack, 1'b1);
		data = wb_dat_r;
		@(posedge clk);
		#2;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	task automatic trav_request(input int lane, input raystore_pkg::trav_req_t req);
		bit done;
		done = 1'b0;
		if (lane == 0) begin
			trav0_req = req;
			trav0_req_valid = 1'b1;
		end else begin
			trav1_req = req;
			trav1_req_valid = 1'b1;
		end
		while (!done) begin
			@(negedge clk);
			if (lane == 0 && !trav0_req_stall) begin
				exp_trav0.push_back(expect_trav(req));
				done = 1'b1;
			end else if (lane == 1 && !trav1_req_stall) begin
				exp_trav1.push_back(expect_trav(req));
				done = 1'b1;
			end
			if (done)
				accepted[lane]++;
			@(posedge clk);
			#2;
		end
		if (lane == 0)
			trav0_req_valid = 1'b0;
		else
			trav1_req_valid = 1'b0;
	endtask

	task automatic ic_request(input raystore_pkg::ic_req_t req);
		raystore_pkg::ic_resp_t e;
		bit done;
		done = 1'b0;
		ic_req = req;
		ic_req_valid = 1'b1;
		while (!done) begin
			@(negedge clk);
			if (!ic_req_stall) begin
				e.ray_id = req.ray_id;
				e.tri_id = req.tri_id;
				e.ray = ray_of(req.ray_id);
				exp_ic.push_back(e);
				accepted[2]++;
				done = 1'b1;
			end
			@(posedge clk);
			#2;
		end
		ic_req_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_trav0.size() + exp_trav1.size() + exp_ic.size() != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic check_idle();
		@(negedge clk);
		check_eq("trav0_resp_valid", trav0_resp_valid, 1'b0);
		check_eq("trav1_resp_valid", trav1_resp_valid, 1'b0);
		check_eq("ic_resp_valid", ic_resp_valid, 1'b0);
		check_eq("req_stall", {trav0_req_stall, trav1_req_stall, ic_req_stall}, 3'b000);
		check_eq("wb_ack", wb_ack, 1'b0);
		check_eq("port_a_busy", i_dut.port_a_busy, 1'b0);
		@(posedge clk);
		#2;
	endtask

	task automatic test_host_access();
		raystore_pkg::float_t data;
		for (int k = 0; k < 16; k++) begin
			for (int w = 0; w < 8; w++) begin
				data = $random(seed);
				wb_write(ray_set[k], w, data);
				if (w < `RS_WORDS)
					model[ray_set[k]][w] = data;
			end
		end
		for (int k = 0; k < 16; k++) begin
			for (int w = 0; w < 8; w++) begin
				wb_read(ray_set[k], w, data);
				if (w < `RS_WORDS)
					check_eq("wb_dat_r", data, model[ray_set[k]][w]);
				else
					check_eq("wb_dat_r", data, 32'h0);
			end
		end
	endtask

	task automatic test_trav_axes();
		raystore_pkg::trav_req_t req;
		for (int lane = 0; lane < 2; lane++) begin
			for (int nt = 0; nt < 4; nt++) begin
				req = random_trav_req();
				req.node_type = raystore_pkg::node_type_t'(nt);
				trav_request(lane, req);
				// idle lane answers in the second cycle after acceptance
				@(negedge clk);
				check_eq(lane == 0 ? "trav0_resp_valid" : "trav1_resp_valid",
					lane == 0 ? trav0_resp_valid : trav1_resp_valid, 1'b0);
				@(negedge clk);
				check_eq(lane == 0 ? "trav0_resp_valid" : "trav1_resp_valid",
					lane == 0 ? trav0_resp_valid : trav1_resp_valid, 1'b1);
				@(posedge clk);
				#2;
			end
		end
		wait_drained();
	endtask

	task automatic test_icache();
		repeat (4) ic_request(random_ic_req());
		wait_drained();
	endtask

	task automatic test_all_clients();
		fork
			repeat (12) trav_request(0, random_trav_req());
			repeat (12) trav_request(1, random_trav_req());
			repeat (12) ic_request(random_ic_req());
		join
		wait_drained();
	endtask

	task automatic test_backpressure();
		int base;
		base = accepted[1];
		trav1_resp_stall = 1'b1;
		fork
			repeat (5) trav_request(1, random_trav_req());
			begin
				repeat (12) @(posedge clk);
				#1;
				check_eq("trav1_accepted", accepted[1] - base, 2);
				check_eq("trav1_req_stall", trav1_req_stall, 1'b1);
				@(posedge clk);
				#2;
				trav1_resp_stall = 1'b0;
			end
		join
		wait_drained();
		// no extra response left behind once all five are in
		@(negedge clk);
		check_eq("trav1_resp_valid", trav1_resp_valid, 1'b0);
		@(posedge clk);
		#2;
	endtask

	task automatic test_interleave();
		raystore_pkg::float_t data;
		fork
			begin
				for (int k = 0; k < 8; k++) begin
					for (int w = 0; w < `RS_WORDS; w++) begin
						data = $random(seed);
						wb_write(new_set[k], w, data);
						model[new_set[k]][w] = data;
					end
				end
			end
			repeat (10) trav_request(0, random_trav_req());
			repeat (10) trav_request(1, random_trav_req());
			repeat (10) ic_request(random_ic_req());
		join
		wait_drained();
		for (int k = 0; k < 8; k++) begin
			for (int w = 0; w < `RS_WORDS; w++) begin
				wb_read(new_set[k], w, data);
				check_eq("wb_dat_r", data, model[new_set[k]][w]);
			end
		end
	endtask

	// response checker and per-cycle acceptance bound
	always @(negedge clk) begin
		if (rst_n) begin
			n_accept = $countones({trav0_req_valid & ~trav0_req_stall,
				trav1_req_valid & ~trav1_req_stall, ic_req_valid & ~ic_req_stall});
			check_eq("accepts_over_two", n_accept > 2, 1'b0);
			if (trav0_resp_valid && !trav0_resp_stall) begin
				if (exp_trav0.size() == 0)
					abort_run("trav0 response arrived with no request outstanding");
				else
					check_eq("trav0_resp", trav0_resp, exp_trav0.pop_front());
			end
			if (trav1_resp_valid && !trav1_resp_stall) begin
				if (exp_trav1.size() == 0)
					abort_run("trav1 response arrived with no request outstanding");
				else
					check_eq("trav1_resp", trav1_resp, exp_trav1.pop_front());
			end
			if (ic_resp_valid && !ic_resp_stall) begin
				if (exp_ic.size() == 0)
					abort_run("icache response arrived with no request outstanding");
				else
					check_eq("ic_resp", ic_resp, exp_ic.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles == MAX_CYCLES)
			abort_run($sformatf("timeout: run exceeded %0d clock cycles", MAX_CYCLES));
	end

	initial begin
		rst_n = 1'b0;
		trav0_req = '0;
		trav0_req_valid = 1'b0;
		trav1_req = '0;
		trav1_req_valid = 1'b0;
		ic_req = '0;
		ic_req_valid = 1'b0;
		trav0_resp_stall = 1'b0;
		trav1_resp_stall = 1'b0;
		ic_resp_stall = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		// two disjoint ray groups spread over the id range
		for (int k = 0; k < 16; k++)
			ray_set[k] = k * 32 + 7;
		for (int k = 0; k < 8; k++)
			new_set[k] = k * 32 + 20;
		repeat (10) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_idle();
		test_host_access();
		test_trav_axes();
		test_icache();
		test_all_clients();
		test_backpressure();
		test_interleave();
		$display("STATUS: PASS");
		$finish;
	end

endmodule : raystore_tb

`default_nettype wire

// File: flist.f
+incdir+hw
hw/raystore_pkg.sv
hw/rs_arb.sv
hw/rs_ray_ram.sv
hw/rs_wb_port.sv
hw/rs_trav_lane.sv
hw/rs_icache_lane.sv
hw/raystore_top.sv
bench/raystore_tb.sv
